// ==== build.f ====
verilog/core_pkg.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/load_store_unit.sv
verilog/axi_arbiter.sv
verilog/core_top.sv
sim/clock_gen.sv
sim/axi_memory.sv
sim/core_checker.sv
sim/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - verilog/core_pkg.sv
  - verilog/register_file.sv
  - verilog/fetch_unit.sv
  - verilog/decode_unit.sv
  - verilog/execute_unit.sv
  - verilog/load_store_unit.sv
  - verilog/axi_arbiter.sv
  - verilog/core_top.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/axi_memory.sv
      - sim/core_checker.sv
      - sim/core_tb.sv

// ==== sim/core_tb.sv ====
module core_tb import core_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] lfsr_seed     = 16'd21798;
	localparam int          reset_timeout = 100;
	localparam int          halt_timeout  = 20000;
	localparam int          drain_cycles  = 20;
	localparam int          mem_words     = 256;
	localparam int          num_stores    = 10;
	localparam logic [6:0]  op_imm        = 7'b0010011;
	localparam logic [6:0]  op_load       = 7'b0000011;

	// stores in program order. skipped markers at 0x120 and 0x128 must not appear.
	localparam addr_t store_addr [num_stores] = '{
		32'h100, 32'h104, 32'h108, 32'h10c, 32'h110,
		32'h114, 32'h118, 32'h11c, 32'h124, 32'h12c
	};
	localparam word_t store_data [num_stores] = '{
		32'h1234_5678, 32'h1234_5668, 32'h1234_5688, 32'h1234_5670, 32'hffff_fff8,
		32'hedcb_a988, 32'h0000_0001, 32'hcafe_0123, 32'hffff_fff0, 32'h0000_0064
	};

	logic clock, reset, halted;
	logic io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
	logic io_master_wlast, io_master_bready, io_master_bvalid;
	logic io_master_arready, io_master_arvalid, io_master_rready, io_master_rvalid;
	logic io_master_rlast;
	addr_t io_master_awaddr, io_master_araddr;
	word_t io_master_wdata, io_master_rdata;
	strb_t io_master_wstrb;
	resp_t io_master_bresp, io_master_rresp;
	logic [3:0] io_master_awid, io_master_arid;
	logic [7:0] io_master_awlen, io_master_arlen;
	logic [2:0] io_master_awsize, io_master_arsize;
	logic [1:0] io_master_awburst, io_master_arburst;
	int error_count = 0;
	int store_count = 0;
	int cycles;

	clock_gen #(.period_ns(20), .reset_cycles(8)) clocks (.clock, .reset);

	axi_memory #(.words(mem_words), .lfsr_seed(lfsr_seed)) memory (
		.clock, .reset,
		.arvalid(io_master_arvalid), .araddr(io_master_araddr), .arready(io_master_arready),
		.rvalid(io_master_rvalid), .rready(io_master_rready), .rdata(io_master_rdata),
		.rresp(io_master_rresp), .rlast(io_master_rlast),
		.awvalid(io_master_awvalid), .awaddr(io_master_awaddr), .awready(io_master_awready),
		.wvalid(io_master_wvalid), .wdata(io_master_wdata), .wready(io_master_wready),
		.bvalid(io_master_bvalid), .bready(io_master_bready), .bresp(io_master_bresp)
	);

	core_top dut (.*);

	bind core_top core_checker protocol_checks (
		.clock, .reset, .halted,
		.arvalid(io_master_arvalid), .arready(io_master_arready), .araddr(io_master_araddr),
		.awvalid(io_master_awvalid), .awready(io_master_awready), .awaddr(io_master_awaddr),
		.wvalid(io_master_wvalid), .wready(io_master_wready), .wdata(io_master_wdata)
	);

	function automatic word_t r_type(input logic [6:0] funct7, input reg_index_t rs2, rs1,
			input logic [2:0] funct3, input reg_index_t rd);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic word_t i_type(input logic [11:0] imm, input reg_index_t rs1,
			input logic [2:0] funct3, input reg_index_t rd, input logic [6:0] opcode);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	// sw rs2, imm(rs1).
	function automatic word_t s_type(input logic [11:0] imm, input reg_index_t rs2, rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_type(input logic [12:0] imm, input reg_index_t rs2, rs1,
			input logic [2:0] funct3);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t lui_word(input logic [19:0] imm, input reg_index_t rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic word_t jal_word(input logic [20:0] imm, input reg_index_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic write_word(input addr_t addr, input word_t data);
		memory.mem[addr / 4] = data;
	endtask

	task automatic compare_field(input string name, input logic [31:0] got, expected);
		field_match: assert (got == expected) else begin
			error_count++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	always @(posedge clock) begin
		// a single word beat is size 2 with burst type INCR.
		if (!reset && io_master_arvalid && io_master_arready) begin
			compare_field("io_master_arid", io_master_arid, 32'd0);
			compare_field("io_master_arlen", io_master_arlen, 32'd0);
			compare_field("io_master_arsize", io_master_arsize, 32'd2);
			compare_field("io_master_arburst", io_master_arburst, 32'd1);
		end
		if (!reset && io_master_awvalid && io_master_awready) begin
			compare_field("io_master_awid", io_master_awid, 32'd0);
			compare_field("io_master_awlen", io_master_awlen, 32'd0);
			compare_field("io_master_awsize", io_master_awsize, 32'd2);
			compare_field("io_master_awburst", io_master_awburst, 32'd1);
		end
		if (!reset && io_master_wvalid && io_master_wready) begin
			compare_field("io_master_wstrb", io_master_wstrb, 32'hf);
			compare_field("io_master_wlast", io_master_wlast, 32'd1);
			store_in_table: assert (store_count < num_stores) else begin
				error_count++;
				$display("store to %h came after the last expected store", io_master_awaddr);
			end
			if (store_count < num_stores) begin
				store_address: assert (io_master_awaddr == store_addr[store_count]) else begin
					error_count++;
					$display("ERROR %0t io_master_awaddr got %h expected %h", $time,
						io_master_awaddr, store_addr[store_count]);
				end
				store_value: assert (io_master_wdata == store_data[store_count]) else begin
					error_count++;
					$display("ERROR %0t io_master_wdata got %h expected %h", $time,
						io_master_wdata, store_data[store_count]);
				end
			end
			store_count <= store_count + 1;
		end
	end

	initial begin
		for (int i = 0; i < mem_words; i++)
			memory.mem[i] = 32'hbad0_0000 | (i * 4);
		write_word(32'h00, lui_word(20'h12345, 5'd1));                     // lui x1, 0x12345
		write_word(32'h04, i_type(12'h678, 5'd1, 3'b000, 5'd1, op_imm));   // addi x1, x1, 0x678
		write_word(32'h08, i_type(12'hff0, 5'd0, 3'b000, 5'd2, op_imm));   // addi x2, x0, -16
		write_word(32'h0c, i_type(12'h100, 5'd0, 3'b000, 5'd10, op_imm));  // addi x10, x0, 0x100
		write_word(32'h10, s_type(12'd0, 5'd1, 5'd10));
		write_word(32'h14, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));       // add x3, x1, x2
		write_word(32'h18, s_type(12'd4, 5'd3, 5'd10));
		write_word(32'h1c, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));       // sub x4, x1, x2
		write_word(32'h20, s_type(12'd8, 5'd4, 5'd10));
		write_word(32'h24, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));       // and x5, x1, x2
		write_word(32'h28, s_type(12'd12, 5'd5, 5'd10));
		write_word(32'h2c, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));       // or x6, x1, x2
		write_word(32'h30, s_type(12'd16, 5'd6, 5'd10));
		write_word(32'h34, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));       // xor x7, x1, x2
		write_word(32'h38, s_type(12'd20, 5'd7, 5'd10));
		write_word(32'h3c, r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));       // slt x8, x2, x1
		write_word(32'h40, s_type(12'd24, 5'd8, 5'd10));
		write_word(32'h44, i_type(12'h080, 5'd10, 3'b010, 5'd9, op_load)); // lw x9, 0x80(x10)
		write_word(32'h48, i_type(12'h123, 5'd9, 3'b000, 5'd9, op_imm));   // addi x9, x9, 0x123
		write_word(32'h4c, s_type(12'd28, 5'd9, 5'd10));
		write_word(32'h50, b_type(13'd8, 5'd1, 5'd1, 3'b000));             // beq, taken.
		write_word(32'h54, s_type(12'd32, 5'd0, 5'd10));
		write_word(32'h58, b_type(13'd8, 5'd1, 5'd1, 3'b001));             // bne, not taken.
		write_word(32'h5c, s_type(12'd36, 5'd2, 5'd10));
		write_word(32'h60, jal_word(21'd8, 5'd11));                        // jal x11, +8
		write_word(32'h64, s_type(12'd40, 5'd0, 5'd10));
		write_word(32'h68, s_type(12'd44, 5'd11, 5'd10));
		write_word(32'h6c, 32'h0010_0073);                                 // ebreak
		write_word(32'h180, 32'hcafe_0000);

		cycles = 0;
		while (reset && cycles < reset_timeout) begin
			@(posedge clock);
			cycles++;
		end
		reset_released: assert (!reset) else begin
			error_count++;
			$display("reset was still applied after %0d cycles", reset_timeout);
		end

		cycles = 0;
		while (!halted && cycles < halt_timeout) begin
			@(posedge clock);
			cycles++;
		end
		halt_seen: assert (halted) else begin
			error_count++;
			$display("the core did not halt within %0d cycles", halt_timeout);
		end
		store_total: assert (store_count == num_stores) else begin
			error_count++;
			$display("ERROR %0t store_count got %0d expected %0d", $time, store_count,
				num_stores);
		end

		repeat (drain_cycles) @(posedge clock); // halted must hold with no further reads.
		$display("errors: %0d testbench checks, %0d protocol assertions", error_count,
			dut.protocol_checks.failures);
		if (error_count == 0 && dut.protocol_checks.failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim/core_checker.sv ====
module core_checker import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  halted,
	input  logic  arvalid,
	input  logic  arready,
	input  addr_t araddr,
	input  logic  awvalid,
	input  logic  awready,
	input  addr_t awaddr,
	input  logic  wvalid,
	input  logic  wready,
	input  word_t wdata
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	ar_held: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
	else begin
		failures++;
		$error("read address dropped or changed before arready");
	end

	aw_held: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
	else begin
		failures++;
		$error("write address dropped or changed before awready");
	end

	w_held: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
	else begin
		failures++;
		$error("write data dropped or changed before wready");
	end

	// the arbiter owns one direction at a time.
	ar_aw_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(arvalid && awvalid))
	else begin
		failures++;
		$error("read and write addresses were valid in the same cycle");
	end

	quiet_in_reset: assert property (@(posedge clock)
		reset |=> !(arvalid || awvalid || wvalid))
	else begin
		failures++;
		$error("a valid was high while reset was applied");
	end

	halt_sticky: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted)
	else begin
		failures++;
		$error("halted fell without a reset");
	end

	no_fetch_after_halt: assert property (@(posedge clock) disable iff (reset)
		halted |-> !arvalid)
	else begin
		failures++;
		$error("a read was issued after the core halted");
	end

endmodule

// ==== sim/axi_memory.sv ====
module axi_memory import core_pkg::*; #(
	parameter int          words     = 256,
	parameter logic [15:0] lfsr_seed = 16'h0001
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  arvalid,
	input  addr_t araddr,
	output logic  arready,
	output logic  rvalid,
	input  logic  rready,
	output word_t rdata,
	output resp_t rresp,
	output logic  rlast,
	input  logic  awvalid,
	input  addr_t awaddr,
	output logic  awready,
	input  logic  wvalid,
	input  word_t wdata,
	output logic  wready,
	output logic  bvalid,
	input  logic  bready,
	output resp_t bresp
);
	timeunit 1ns;
	timeprecision 100ps;

	word_t mem [words];
	logic [15:0] lfsr;
	logic read_busy, write_busy, aw_seen, w_seen;
	int read_wait, write_wait;
	addr_t read_addr, write_addr;
	word_t write_data;

	assign rresp = 2'b00;
	assign bresp = 2'b00;
	assign rlast = 1'b1; // every burst is a single beat.

	// taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic draw(input int bits, output int value);
		value = 0;
		repeat (bits) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	initial begin
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
	end

	always @(posedge clock) begin
		int pick;
		if (reset) begin
			lfsr = lfsr_seed;
			arready    <= 1'b0;
			rvalid     <= 1'b0;
			awready    <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			read_busy  <= 1'b0;
			write_busy <= 1'b0;
			aw_seen    <= 1'b0;
			w_seen     <= 1'b0;
		end else begin
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (arvalid && arready) begin
				arready   <= 1'b0;
				read_addr <= araddr;
				draw(2, pick);
				read_wait <= pick;
				read_busy <= 1'b1;
			end else if (arvalid && !read_busy && !rvalid) begin
				draw(1, pick);
				arready <= pick[0]; // ready comes on a coin toss each cycle.
			end
			if (read_busy) begin
				if (read_wait == 0) begin
					rvalid    <= 1'b1;
					rdata     <= mem[read_addr / 4];
					read_busy <= 1'b0;
				end else begin
					read_wait <= read_wait - 1;
				end
			end

			if (bvalid && bready)
				bvalid <= 1'b0;
			if (awvalid && awready) begin
				awready    <= 1'b0;
				write_addr <= awaddr;
				aw_seen    <= 1'b1;
			end else if (awvalid && !aw_seen && !write_busy && !bvalid) begin
				draw(1, pick);
				awready <= pick[0];
			end
			if (wvalid && wready) begin
				wready     <= 1'b0;
				write_data <= wdata;
				w_seen     <= 1'b1;
			end else if (wvalid && !w_seen && !write_busy && !bvalid) begin
				draw(1, pick);
				wready <= pick[0];
			end
			// the word is stored once both address and data have arrived.
			if (aw_seen && w_seen) begin
				mem[write_addr / 4] <= write_data;
				aw_seen    <= 1'b0;
				w_seen     <= 1'b0;
				draw(2, pick);
				write_wait <= pick;
				write_busy <= 1'b1;
			end
			if (write_busy) begin
				if (write_wait == 0) begin
					bvalid     <= 1'b1;
					write_busy <= 1'b0;
				end else begin
					write_wait <= write_wait - 1;
				end
			end
		end
	end

endmodule

// ==== sim/clock_gen.sv ====
module clock_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 8
) (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	always #(period_ns / 2) clock = ~clock;

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0; // released on a rising edge like every other input.
	end

endmodule

// ==== verilog/core_top.sv ====
module core_top import core_pkg::*; #(
	parameter addr_t boot_address = reset_pc
) (
	input  logic       clock,
	input  logic       reset,
	output logic       halted,

	input  logic       io_master_awready,
	output logic       io_master_awvalid,
	output addr_t      io_master_awaddr,
	output logic [3:0] io_master_awid,
	output logic [7:0] io_master_awlen,
	output logic [2:0] io_master_awsize,
	output logic [1:0] io_master_awburst,

	input  logic       io_master_wready,
	output logic       io_master_wvalid,
	output word_t      io_master_wdata,
	output strb_t      io_master_wstrb,
	output logic       io_master_wlast,

	output logic       io_master_bready,
	input  logic       io_master_bvalid,
	input  resp_t      io_master_bresp,

	input  logic       io_master_arready,
	output logic       io_master_arvalid,
	output addr_t      io_master_araddr,
	output logic [3:0] io_master_arid,
	output logic [7:0] io_master_arlen,
	output logic [2:0] io_master_arsize,
	output logic [1:0] io_master_arburst,

	output logic       io_master_rready,
	input  logic       io_master_rvalid,
	input  resp_t      io_master_rresp,
	input  word_t      io_master_rdata,
	input  logic       io_master_rlast
);

	logic inst_valid, inst_ready, dec_valid, dec_ready, exe_valid, exe_ready;
	logic is_load, is_store, is_halt, exe_wen;
	logic wb_valid, wb_en, halt_req;
	logic if_arvalid, if_arready, if_rvalid;
	logic ls_arvalid, ls_arready, ls_rvalid, ls_awvalid, ls_awready;
	logic ls_wvalid, ls_wready, ls_bvalid;
	word_t inst, rs1_data, rs2_data, src1, src2, imm, result, store_data, wb_data;
	word_t if_rdata, ls_rdata, ls_wdata;
	addr_t inst_pc, dec_pc, mem_addr, next_pc, wb_next_pc, if_araddr, ls_araddr, ls_awaddr;
	reg_index_t rs1, rs2, rd, exe_rd, wb_rd;
	resp_t if_rresp, ls_rresp, ls_bresp;
	op_class_t op_class;
	alu_op_t alu_op;

	fetch_unit #(.boot_address(boot_address)) fetch (
		.clock, .reset, .wb_valid, .next_pc(wb_next_pc), .halt_req,
		.inst_valid, .inst, .inst_pc, .inst_ready,
		.if_arvalid, .if_araddr, .if_arready, .if_rvalid, .if_rdata, .if_rresp, .halted
	);

	decode_unit decode (
		.clock, .reset, .inst_valid, .inst, .inst_pc, .inst_ready,
		.rs1, .rs2, .rs1_data, .rs2_data, .dec_valid, .dec_ready,
		.op_class, .alu_op, .rd, .src1, .src2, .imm, .dec_pc
	);

	register_file regs (
		.clock, .rs1, .rs2, .rs1_data, .rs2_data, .wb_valid, .wb_en, .wb_rd, .wb_data
	);

	execute_unit execute (
		.clock, .reset, .dec_valid, .dec_ready,
		.op_class, .alu_op, .rd, .src1, .src2, .imm, .dec_pc, .exe_valid, .exe_ready,
		.result, .store_data, .mem_addr, .is_load, .is_store, .is_halt, .exe_rd, .exe_wen, .next_pc
	);

	load_store_unit lsu (
		.clock, .reset, .exe_valid, .exe_ready,
		.result, .store_data, .mem_addr, .is_load, .is_store, .is_halt, .exe_rd, .exe_wen, .next_pc,
		.ls_arvalid, .ls_araddr, .ls_arready, .ls_rvalid, .ls_rdata, .ls_rresp,
		.ls_awvalid, .ls_awaddr, .ls_awready, .ls_wvalid, .ls_wdata, .ls_wready,
		.ls_bvalid, .ls_bresp, .wb_valid, .wb_en, .wb_rd, .wb_data, .halt_req, .wb_next_pc
	);

	axi_arbiter arbiter (
		.clock, .reset,
		.if_arvalid, .if_araddr, .if_arready, .if_rvalid, .if_rdata, .if_rresp,
		.ls_arvalid, .ls_araddr, .ls_arready, .ls_rvalid, .ls_rdata, .ls_rresp,
		.ls_awvalid, .ls_awaddr, .ls_awready, .ls_wvalid, .ls_wdata, .ls_wready,
		.ls_bvalid, .ls_bresp,
		.axi_arvalid(io_master_arvalid), .axi_araddr(io_master_araddr),
		.axi_arready(io_master_arready), .axi_rvalid(io_master_rvalid),
		.axi_rready(io_master_rready), .axi_rdata(io_master_rdata),
		.axi_rresp(io_master_rresp), .axi_rlast(io_master_rlast),
		.axi_awvalid(io_master_awvalid), .axi_awaddr(io_master_awaddr),
		.axi_awready(io_master_awready), .axi_wvalid(io_master_wvalid),
		.axi_wdata(io_master_wdata), .axi_wready(io_master_wready),
		.axi_bvalid(io_master_bvalid), .axi_bready(io_master_bready),
		.axi_bresp(io_master_bresp)
	);

	// every transfer is one full word beat with id zero.
	assign io_master_arid    = '0;
	assign io_master_arlen   = '0;
	assign io_master_arsize  = axi_size_word;
	assign io_master_arburst = axi_burst_incr;
	assign io_master_awid    = '0;
	assign io_master_awlen   = '0;
	assign io_master_awsize  = axi_size_word;
	assign io_master_awburst = axi_burst_incr;
	assign io_master_wstrb   = '1;
	assign io_master_wlast   = 1'b1;

endmodule

// ==== verilog/axi_arbiter.sv ====
module axi_arbiter import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  if_arvalid,
	input  addr_t if_araddr,
	output logic  if_arready,
	output logic  if_rvalid,
	output word_t if_rdata,
	output resp_t if_rresp,
	input  logic  ls_arvalid,
	input  addr_t ls_araddr,
	output logic  ls_arready,
	output logic  ls_rvalid,
	output word_t ls_rdata,
	output resp_t ls_rresp,
	input  logic  ls_awvalid,
	input  addr_t ls_awaddr,
	output logic  ls_awready,
	input  logic  ls_wvalid,
	input  word_t ls_wdata,
	output logic  ls_wready,
	output logic  ls_bvalid,
	output resp_t ls_bresp,
	output logic  axi_arvalid,
	output addr_t axi_araddr,
	input  logic  axi_arready,
	input  logic  axi_rvalid,
	output logic  axi_rready,
	input  word_t axi_rdata,
	input  resp_t axi_rresp,
	input  logic  axi_rlast,
	output logic  axi_awvalid,
	output addr_t axi_awaddr,
	input  logic  axi_awready,
	output logic  axi_wvalid,
	output word_t axi_wdata,
	input  logic  axi_wready,
	input  logic  axi_bvalid,
	output logic  axi_bready,
	input  resp_t axi_bresp
);

	typedef enum logic [1:0] {
		own_idle,
		own_read,
		own_write
	} owner_t;

	owner_t owner;
	logic grant_ls; // writes only ever come from load/store.
	logic reading, writing;

	always_ff @(posedge clock) begin
		if (reset) begin
			owner    <= own_idle;
			grant_ls <= 1'b0;
		end else begin
			case (owner)
				own_idle: begin
					// load/store wins a tie with fetch.
					if (ls_arvalid) begin
						owner    <= own_read;
						grant_ls <= 1'b1;
					end else if (ls_awvalid) begin
						owner    <= own_write;
						grant_ls <= 1'b1;
					end else if (if_arvalid) begin
						owner    <= own_read;
						grant_ls <= 1'b0;
					end
				end
				own_read: begin
					if (axi_rvalid && axi_rlast)
						owner <= own_idle; // rready is high for the whole read.
				end
				own_write: begin
					if (axi_bvalid)
						owner <= own_idle;
				end
				default: owner <= own_idle;
			endcase
		end
	end

	assign reading = (owner == own_read);
	assign writing = (owner == own_write);

	assign axi_arvalid = reading && (grant_ls ? ls_arvalid : if_arvalid);
	assign axi_araddr  = grant_ls ? ls_araddr : if_araddr;
	assign axi_rready  = reading;
	assign if_arready  = reading && !grant_ls && axi_arready;
	assign ls_arready  = reading && grant_ls && axi_arready;
	assign if_rvalid   = reading && !grant_ls && axi_rvalid;
	assign ls_rvalid   = reading && grant_ls && axi_rvalid;
	assign if_rdata    = axi_rdata;
	assign if_rresp    = axi_rresp;
	assign ls_rdata    = axi_rdata;
	assign ls_rresp    = axi_rresp;

	assign axi_awvalid = writing && ls_awvalid;
	assign axi_awaddr  = ls_awaddr;
	assign axi_wvalid  = writing && ls_wvalid;
	assign axi_wdata   = ls_wdata;
	assign axi_bready  = writing;
	assign ls_awready  = writing && axi_awready;
	assign ls_wready   = writing && axi_wready;
	assign ls_bvalid   = writing && axi_bvalid;
	assign ls_bresp    = axi_bresp;

endmodule

// ==== verilog/load_store_unit.sv ====
module load_store_unit import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       exe_valid,
	output logic       exe_ready,
	input  word_t      result,
	input  word_t      store_data,
	input  addr_t      mem_addr,
	input  logic       is_load,
	input  logic       is_store,
	input  logic       is_halt,
	input  reg_index_t exe_rd,
	input  logic       exe_wen,
	input  addr_t      next_pc,
	output logic       ls_arvalid,
	output addr_t      ls_araddr,
	input  logic       ls_arready,
	input  logic       ls_rvalid,
	input  word_t      ls_rdata,
	input  resp_t      ls_rresp,
	output logic       ls_awvalid,
	output addr_t      ls_awaddr,
	input  logic       ls_awready,
	output logic       ls_wvalid,
	output word_t      ls_wdata,
	input  logic       ls_wready,
	input  logic       ls_bvalid,
	input  resp_t      ls_bresp,
	output logic       wb_valid,
	output logic       wb_en,
	output reg_index_t wb_rd,
	output word_t      wb_data,
	output logic       halt_req,
	output addr_t      wb_next_pc
);

	typedef enum logic [1:0] {
		ls_idle,
		ls_read,
		ls_write,
		ls_done
	} lsu_state_t;

	lsu_state_t state;
	addr_t addr_q;

	assign exe_ready = (state == ls_idle);
	assign wb_valid  = (state == ls_done); // done lasts exactly one cycle.
	assign ls_araddr = addr_q;
	assign ls_awaddr = addr_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= ls_idle;
			ls_arvalid <= 1'b0;
			ls_awvalid <= 1'b0;
			ls_wvalid  <= 1'b0;
		end else begin
			case (state)
				ls_idle: begin
					if (exe_valid) begin
						wb_rd      <= exe_rd;
						wb_en      <= exe_wen;
						wb_data    <= result;
						halt_req   <= is_halt;
						wb_next_pc <= next_pc;
						addr_q     <= mem_addr;
						ls_wdata   <= store_data;
						if (is_load) begin
							ls_arvalid <= 1'b1;
							state      <= ls_read;
						end else if (is_store) begin
							ls_awvalid <= 1'b1; // address and data go out together.
							ls_wvalid  <= 1'b1;
							state      <= ls_write;
						end else begin
							state <= ls_done;
						end
					end
				end
				ls_read: begin
					if (ls_arready)
						ls_arvalid <= 1'b0;
					if (ls_rvalid) begin
						wb_data  <= ls_rdata;
						halt_req <= (ls_rresp != resp_okay); // a bus error stops the core.
						state    <= ls_done;
					end
				end
				ls_write: begin
					if (ls_awready)
						ls_awvalid <= 1'b0;
					if (ls_wready)
						ls_wvalid <= 1'b0;
					if (ls_bvalid) begin
						halt_req <= (ls_bresp != resp_okay);
						state    <= ls_done;
					end
				end
				default: state <= ls_idle;
			endcase
		end
	end

endmodule

// ==== verilog/execute_unit.sv ====
module execute_unit import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       dec_valid,
	output logic       dec_ready,
	input  op_class_t  op_class,
	input  alu_op_t    alu_op,
	input  reg_index_t rd,
	input  word_t      src1,
	input  word_t      src2,
	input  word_t      imm,
	input  addr_t      dec_pc,
	output logic       exe_valid,
	input  logic       exe_ready,
	output word_t      result,
	output word_t      store_data,
	output addr_t      mem_addr,
	output logic       is_load,
	output logic       is_store,
	output logic       is_halt,
	output reg_index_t exe_rd,
	output logic       exe_wen,
	output addr_t      next_pc
);

	word_t operand_b, alu_out;
	addr_t pc_plus4;
	logic taken;

	assign dec_ready = !exe_valid || exe_ready;
	assign operand_b = (op_class == alu_reg || op_class == branch_op) ? src2 : imm;
	assign pc_plus4  = dec_pc + 32'd4;

	always_comb begin
		case (alu_op)
			alu_add: alu_out = src1 + operand_b;
			alu_sub: alu_out = src1 - operand_b;
			alu_and: alu_out = src1 & operand_b;
			alu_or:  alu_out = src1 | operand_b;
			alu_xor: alu_out = src1 ^ operand_b;
			alu_slt: alu_out = {31'b0, $signed(src1) < $signed(operand_b)};
			default: alu_out = operand_b;
		endcase
	end

	// both branch forms give zero when the operands are equal; sub marks beq.
	assign taken = (op_class == branch_op) && ((alu_op == alu_sub) == (alu_out == '0));

	always_ff @(posedge clock) begin
		if (reset) begin
			exe_valid <= 1'b0;
		end else if (dec_valid && dec_ready) begin
			exe_valid  <= 1'b1;
			result     <= (op_class == jal_op) ? pc_plus4 : alu_out;
			store_data <= src2;
			mem_addr   <= alu_out; // loads and stores add rs1 and the immediate.
			is_load    <= (op_class == load_op);
			is_store   <= (op_class == store_op);
			is_halt    <= (op_class == halt_op) || (op_class == illegal_op);
			exe_rd     <= rd;
			exe_wen    <= op_class inside {alu_reg, alu_imm, lui_op, jal_op, load_op};
			next_pc    <= (op_class == jal_op || taken) ? dec_pc + imm : pc_plus4;
		end else if (exe_ready) begin
			exe_valid <= 1'b0;
		end
	end

endmodule

// ==== verilog/decode_unit.sv ====
module decode_unit import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       inst_valid,
	input  word_t      inst,
	input  addr_t      inst_pc,
	output logic       inst_ready,
	output reg_index_t rs1,
	output reg_index_t rs2,
	input  word_t      rs1_data,
	input  word_t      rs2_data,
	output logic       dec_valid,
	input  logic       dec_ready,
	output op_class_t  op_class,
	output alu_op_t    alu_op,
	output reg_index_t rd,
	output word_t      src1,
	output word_t      src2,
	output word_t      imm,
	output addr_t      dec_pc
);

	word_t imm_i, imm_s, imm_b, imm_u, imm_j, imm_next;
	op_class_t class_next;
	alu_op_t alu_next;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign rs1        = inst[19:15];
	assign rs2        = inst[24:20];
	assign funct3     = inst[14:12];
	assign funct7     = inst[31:25];
	assign inst_ready = !dec_valid || dec_ready;

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		class_next = illegal_op;
		alu_next   = alu_add;
		imm_next   = imm_i;
		case (inst[6:0])
			opc_lui: begin
				class_next = lui_op;
				alu_next   = alu_pass_b;
				imm_next   = imm_u;
			end
			opc_op_imm: begin
				if (funct3 == 3'b000)
					class_next = alu_imm; // addi only.
			end
			opc_op: begin
				class_next = alu_reg;
				case ({funct7, funct3})
					10'b0000000_000: alu_next = alu_add;
					10'b0100000_000: alu_next = alu_sub;
					10'b0000000_111: alu_next = alu_and;
					10'b0000000_110: alu_next = alu_or;
					10'b0000000_100: alu_next = alu_xor;
					10'b0000000_010: alu_next = alu_slt;
					default:         class_next = illegal_op;
				endcase
			end
			opc_branch: begin
				// beq travels as sub and bne as xor.
				imm_next = imm_b;
				if (funct3 == 3'b000) begin
					class_next = branch_op;
					alu_next   = alu_sub;
				end else if (funct3 == 3'b001) begin
					class_next = branch_op;
					alu_next   = alu_xor;
				end
			end
			opc_jal: begin
				class_next = jal_op;
				imm_next   = imm_j;
			end
			opc_load: begin
				if (funct3 == 3'b010)
					class_next = load_op;
			end
			opc_store: begin
				imm_next = imm_s;
				if (funct3 == 3'b010)
					class_next = store_op;
			end
			opc_system: begin
				if (inst == ebreak_inst)
					class_next = halt_op;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (inst_valid && inst_ready) begin
			dec_valid <= 1'b1;
			op_class  <= class_next;
			alu_op    <= alu_next;
			rd        <= inst[11:7];
			src1      <= rs1_data;
			src2      <= rs2_data;
			imm       <= imm_next;
			dec_pc    <= inst_pc;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;
		end
	end

endmodule

// ==== verilog/fetch_unit.sv ====
module fetch_unit import core_pkg::*; #(
	parameter addr_t boot_address = reset_pc
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  wb_valid,
	input  addr_t next_pc,
	input  logic  halt_req,
	output logic  inst_valid,
	output word_t inst,
	output addr_t inst_pc,
	input  logic  inst_ready,
	output logic  if_arvalid,
	output addr_t if_araddr,
	input  logic  if_arready,
	input  logic  if_rvalid,
	input  word_t if_rdata,
	input  resp_t if_rresp,
	output logic  halted
);

	typedef enum logic [2:0] {
		fs_request,
		fs_wait_data,
		fs_hand_off,
		fs_wait_wb,
		fs_stopped
	} fetch_state_t;

	fetch_state_t state;
	addr_t pc;

	assign if_araddr  = pc;
	assign inst_pc    = pc; // pc only moves at writeback.
	assign inst_valid = (state == fs_hand_off);
	assign halted     = (state == fs_stopped);

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= fs_request;
			pc         <= boot_address;
			if_arvalid <= 1'b0;
		end else begin
			case (state)
				fs_request: begin
					if (if_arvalid && if_arready) begin
						if_arvalid <= 1'b0;
						state      <= fs_wait_data;
					end else begin
						if_arvalid <= 1'b1;
					end
				end
				fs_wait_data: begin
					if (if_rvalid) begin
						// a failed read becomes an all-zero word, which decodes as illegal.
						inst  <= (if_rresp == resp_okay) ? if_rdata : '0;
						state <= fs_hand_off;
					end
				end
				fs_hand_off: begin
					if (inst_ready)
						state <= fs_wait_wb;
				end
				fs_wait_wb: begin
					if (wb_valid) begin
						pc <= next_pc;
						if (halt_req) begin
							state <= fs_stopped;
						end else begin
							state      <= fs_request;
							if_arvalid <= 1'b1; // next read goes out straight away.
						end
					end
				end
				default: ; // stopped stays until reset.
			endcase
		end
	end

endmodule

// ==== verilog/register_file.sv ====
module register_file import core_pkg::*; (
	input  logic       clock,
	input  reg_index_t rs1,
	input  reg_index_t rs2,
	output word_t      rs1_data,
	output word_t      rs2_data,
	input  logic       wb_valid,
	input  logic       wb_en,
	input  reg_index_t wb_rd,
	input  word_t      wb_data
);

	word_t regs [32]; // entry 0 is never written.

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clock) begin
		if (wb_valid && wb_en && (wb_rd != '0)) begin
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_index_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	typedef enum logic [3:0] {
		alu_reg,
		alu_imm,
		lui_op,
		branch_op,
		jal_op,
		load_op,
		store_op,
		halt_op,
		illegal_op
	} op_class_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	// major opcodes of the supported RV32I subset.
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_jal    = 7'b1101111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_t;

	localparam addr_t      reset_pc       = 32'h0000_0000;
	localparam word_t      ebreak_inst    = 32'h0010_0073;
	localparam resp_t      resp_okay      = 2'b00;
	localparam logic [2:0] axi_size_word  = 3'b010;
	localparam logic [1:0] axi_burst_incr = 2'b01;

endpackage
